// File: video_config.svh
// Fixed 640x480 timing at one pixel per clk; image and memory sizes must match the package types
`ifndef VIDEO_CONFIG_SVH
`define VIDEO_CONFIG_SVH

// Horizontal geometry in clocks
`define H_TOTAL        800
`define H_VISIBLE      640
`define H_SYNC_START   656
`define H_SYNC_END     752

// Vertical geometry in lines
`define V_TOTAL        525
`define V_VISIBLE      480
`define V_SYNC_START   490
`define V_SYNC_END     492

// Image size, each image pixel covers 2x2 screen pixels
`define IMAGE_WIDTH    320
`define IMAGE_HEIGHT   240

// Memory depths in entries
`define MAP_DEPTH      1024
`define TILE_DEPTH     32768
`define PAL_DEPTH      256
`define LINE_BUF_DEPTH 1024

// Clocks from render column issue to line buffer write
// Tilemap read, tile graphics read, palette read
`define RENDER_DELAY   3

`endif

// File: video_timing_pkg.sv
// Widths assume a scan counter below 1024 and a 320x240 image
package video_timing_pkg;

  // Horizontal or vertical scan counter
  typedef logic [9:0] scan_pos_t;

  // Image coordinates after pixel doubling
  typedef logic [8:0] screen_x_t;
  typedef logic [7:0] screen_y_t;

  // Buffer half in the top bit, image column below
  typedef logic [9:0] line_buf_addr_t;

  // Horizontal sync and blank travelling together to the output
  typedef struct packed {
    logic hsync;
    logic blank;
  } sync_bundle_t;

  // One line buffer write command
  typedef struct packed {
    logic           wr_en;
    line_buf_addr_t addr;
  } buf_write_t;

endpackage

// File: tile_pkg.sv
// Tilemap entries are bare tile numbers with no flags; the world is 32x32 tiles of 16x16 pixels
package tile_pkg;

  // Memory or register block selected by a host write
  typedef enum logic [1:0] {
    TGT_REG,
    TGT_MAP,
    TGT_TILE,
    TGT_PAL
  } host_target_t;

  // Register picked by the low host address bit
  typedef enum logic {
    REG_SCROLL_X,
    REG_SCROLL_Y
  } reg_index_t;

  // Tile row in the top 5 bits, tile column in the low 5
  typedef logic [9:0] map_addr_t;
  typedef logic [7:0] tile_num_t;

  // Tile number, pixel row, pixel column pair
  typedef logic [14:0] tile_addr_t;
  // Two palette indices, even column in the low byte
  typedef logic [15:0] tile_word_t;
  typedef logic [7:0] pal_index_t;

  // Blue in [23:16], green in [15:8], red in [7:0]
  typedef logic [23:0] color24_t;
  // Blue, green and red, 6 bits each in that order
  typedef logic [17:0] rgb18_t;

  // Host bus fields
  typedef logic [14:0] host_addr_t;
  typedef logic [23:0] host_data_t;

  // Scroll offset in the 512x512 world
  typedef logic [8:0] scroll_t;

endpackage

// File: display_timing.sv
// Sync is active high; blank is horizontal only, vertical blanking comes two lines late
`timescale 1ns/1ns

`include "video_config.svh"

module display_timing (
  input  logic                        clk,
  input  logic                        reset,
  output video_timing_pkg::scan_pos_t h_pos,
  output video_timing_pkg::scan_pos_t v_pos,
  output logic                        hsync,
  output logic                        blank,
  output video_timing_pkg::scan_pos_t h_visible,
  output video_timing_pkg::scan_pos_t v_visible,
  output logic                        vsync_late,
  output logic                        v_blank_late
);

  // Line count two lines back, wrapped over the frame
  video_timing_pkg::scan_pos_t v_late;

  // h_pos runs every clock, v_pos steps on the horizontal wrap
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      h_pos <= '0;
      v_pos <= '0;
    end else if (h_pos == `H_TOTAL - 1) begin
      h_pos <= '0;
      if (v_pos == `V_TOTAL - 1) begin
        v_pos <= '0;
      end else begin
        v_pos <= v_pos + 1'b1;
      end
    end else begin
      h_pos <= h_pos + 1'b1;
    end
  end

  // Current position decode
  assign hsync = (h_pos >= `H_SYNC_START) && (h_pos < `H_SYNC_END);
  assign blank = (h_pos >= `H_VISIBLE);

  // Visible positions read as zero outside the active area
  assign h_visible = blank ? '0 : h_pos;
  assign v_visible = (v_pos < `V_VISIBLE) ? v_pos : '0;

  always_comb begin
    if (v_pos >= 2) begin
      v_late = v_pos - 2'd2;
    end else begin
      v_late = v_pos + video_timing_pkg::scan_pos_t'(`V_TOTAL - 2);
    end
  end

  // Late decode lines up with the line buffer scanout
  assign vsync_late   = (v_late >= `V_SYNC_START) && (v_late < `V_SYNC_END);
  assign v_blank_late = (v_late >= `V_VISIBLE);

endmodule

// File: pipe_delay.sv
// DELAY must be at least 1; every stage clears to zero on reset
`timescale 1ns/1ns

module pipe_delay #(
  parameter type T     = logic,
  parameter int  DELAY = 1
) (
  input  logic clk,
  input  logic reset,
  input  T     d,
  output T     q
);

  // Stage 0 takes the input, the last stage drives q
  T stages [DELAY];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < DELAY; i++) begin
        stages[i] <= '0;
      end
    end else begin
      stages[0] <= d;
      for (int i = 1; i < DELAY; i++) begin
        stages[i] <= stages[i - 1];
      end
    end
  end

  assign q = stages[DELAY - 1];

endmodule

// File: scroll_registers.sv
// Write only; a new scroll value is seen by the renderer from the next column it issues
`timescale 1ns/1ns

module scroll_registers (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  host_wr,
  input  tile_pkg::host_target_t host_target,
  input  tile_pkg::host_addr_t  host_addr,
  input  tile_pkg::host_data_t  host_data,
  output tile_pkg::scroll_t     scroll_x,
  output tile_pkg::scroll_t     scroll_y
);

  // Register write decode
  logic                 reg_write;
  tile_pkg::reg_index_t reg_sel;

  assign reg_write = host_wr && (host_target == tile_pkg::TGT_REG);
  assign reg_sel   = tile_pkg::reg_index_t'(host_addr[0]);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      scroll_x <= '0;
      scroll_y <= '0;
    end else if (reg_write) begin
      // Upper data bits drop, so offsets wrap at 512
      case (reg_sel)
        tile_pkg::REG_SCROLL_X: scroll_x <= host_data[8:0];
        tile_pkg::REG_SCROLL_Y: scroll_y <= host_data[8:0];
        default: scroll_x <= scroll_x;
      endcase
    end
  end

endmodule

// File: tile_memories.sv
// No host read back; contents are undefined until the host writes them
`timescale 1ns/1ns

`include "video_config.svh"

module tile_memories (
  input  logic                   clk,
  input  logic                   host_wr,
  input  tile_pkg::host_target_t host_target,
  input  tile_pkg::host_addr_t   host_addr,
  input  tile_pkg::host_data_t   host_data,
  input  tile_pkg::map_addr_t    map_addr,
  input  tile_pkg::tile_addr_t   tile_addr,
  input  tile_pkg::pal_index_t   pal_index,
  output tile_pkg::tile_num_t    map_data,
  output tile_pkg::tile_word_t   tile_data,
  output tile_pkg::color24_t     pal_data
);

  tile_pkg::tile_num_t  map_mem  [`MAP_DEPTH];
  tile_pkg::tile_word_t tile_mem [`TILE_DEPTH];
  tile_pkg::color24_t   pal_mem  [`PAL_DEPTH];

  // Per target write strobes
  logic map_wr;
  logic tile_wr;
  logic pal_wr;

  assign map_wr  = host_wr && (host_target == tile_pkg::TGT_MAP);
  assign tile_wr = host_wr && (host_target == tile_pkg::TGT_TILE);
  assign pal_wr  = host_wr && (host_target == tile_pkg::TGT_PAL);

  // Tilemap, low 10 address bits
  always_ff @(posedge clk) begin
    if (map_wr) begin
      map_mem[host_addr[9:0]] <= host_data[7:0];
    end
    map_data <= map_mem[map_addr];
  end

  // Tile graphics, full 15-bit word address
  always_ff @(posedge clk) begin
    if (tile_wr) begin
      tile_mem[host_addr] <= host_data[15:0];
    end
    tile_data <= tile_mem[tile_addr];
  end

  // Palette, low 8 address bits
  always_ff @(posedge clk) begin
    if (pal_wr) begin
      pal_mem[host_addr[7:0]] <= host_data;
    end
    pal_data <= pal_mem[pal_index];
  end

endmodule

// File: line_buffer.sv
// Read during write to the same address returns the old color
`timescale 1ns/1ns

`include "video_config.svh"

module line_buffer (
  input  logic                             clk,
  input  logic                             wr_en,
  input  video_timing_pkg::line_buf_addr_t wr_addr,
  input  tile_pkg::color24_t               wr_data,
  input  video_timing_pkg::line_buf_addr_t rd_addr,
  output tile_pkg::color24_t               rd_data
);

  // Two halves of 512 colors, only 320 of each in use
  tile_pkg::color24_t mem [`LINE_BUF_DEPTH];

  // Renderer side
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Scanout side, data one clock after the address
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

// File: tile_renderer.sv
// Draws one image row per even visible line; video outputs trail the scan position by 2 clocks
`timescale 1ns/1ns

`include "video_config.svh"

module tile_renderer (
  input  logic                             clk,
  input  logic                             reset,
  input  video_timing_pkg::scan_pos_t      h_pos,
  input  video_timing_pkg::scan_pos_t      v_pos,
  input  logic                             hsync,
  input  logic                             blank,
  input  video_timing_pkg::scan_pos_t      h_visible,
  input  video_timing_pkg::scan_pos_t      v_visible,
  input  logic                             vsync_late,
  input  logic                             v_blank_late,
  input  tile_pkg::scroll_t                scroll_x,
  input  tile_pkg::scroll_t                scroll_y,
  output tile_pkg::map_addr_t              map_addr,
  output tile_pkg::tile_addr_t             tile_addr,
  output tile_pkg::pal_index_t             pal_index,
  input  tile_pkg::tile_num_t              map_data,
  input  tile_pkg::tile_word_t             tile_data,
  input  tile_pkg::color24_t               pal_data,
  output logic                             buf_wr_en,
  output video_timing_pkg::line_buf_addr_t buf_wr_addr,
  output tile_pkg::color24_t               buf_wr_data,
  output video_timing_pkg::line_buf_addr_t buf_rd_addr,
  input  tile_pkg::color24_t               buf_rd_data,
  output logic                             hsync_out,
  output logic                             vsync_out,
  output logic                             de,
  output tile_pkg::rgb18_t                 rgb
);

  typedef enum logic {
    ST_IDLE,
    ST_DRAW
  } render_state_t;

  render_state_t               state;
  video_timing_pkg::screen_x_t render_x;
  video_timing_pkg::screen_y_t screen_y;

  // World coordinates, 9 bits so they wrap at 512
  logic [8:0] world_x;
  logic [8:0] world_y;

  // Pixel position inside the tile, following the fetch pipeline
  logic [3:0] tile_row_q;
  logic [3:0] tile_col_q;
  logic       byte_sel_q;

  video_timing_pkg::buf_write_t   wr_cmd;
  video_timing_pkg::buf_write_t   wr_cmd_q;
  video_timing_pkg::sync_bundle_t sync_in;
  video_timing_pkg::sync_bundle_t sync_q;
  tile_pkg::color24_t             color_q;

  // Both lines of a pair share one image row
  assign screen_y = v_visible[8:1];

  // Column issue, one per clock while drawing
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state    <= ST_IDLE;
      render_x <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          // Start of an even visible line
          if ((h_pos == '0) && (v_pos < `V_VISIBLE) && !v_visible[0]) begin
            state    <= ST_DRAW;
            render_x <= '0;
          end
        end
        ST_DRAW: begin
          // Last column, or the odd line is running out
          if ((render_x == `IMAGE_WIDTH - 1) ||
              ((h_pos == `H_TOTAL - 1) && v_visible[0])) begin
            state <= ST_IDLE;
          end else begin
            render_x <= render_x + 1'b1;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Scroll and wrap
  assign world_x = render_x + scroll_x;
  assign world_y = {1'b0, screen_y} + scroll_y;

  // Stage t, tile row and column select the map entry
  assign map_addr = {world_y[8:4], world_x[8:4]};

  always_ff @(posedge clk) begin
    tile_row_q <= world_y[3:0];
    tile_col_q <= world_x[3:0];
    byte_sel_q <= tile_col_q[0];
  end

  // Stage t+1, tile number plus pixel row and column pair
  assign tile_addr = {map_data, tile_row_q, tile_col_q[3:1]};

  // Stage t+2, odd world column is the high byte
  assign pal_index = byte_sel_q ? tile_data[15:8] : tile_data[7:0];

  // Write command follows the fetch to stage t+3
  always_comb begin
    wr_cmd.wr_en = (state == ST_DRAW);
    wr_cmd.addr  = {screen_y[0], render_x};
  end

  pipe_delay #(
    .T     (video_timing_pkg::buf_write_t),
    .DELAY (`RENDER_DELAY)
  ) write_delay (
    .clk   (clk),
    .reset (reset),
    .d     (wr_cmd),
    .q     (wr_cmd_q)
  );

  assign buf_wr_en   = wr_cmd_q.wr_en;
  assign buf_wr_addr = wr_cmd_q.addr;
  assign buf_wr_data = pal_data;

  // Scanout reads the half drawn during the previous line pair
  assign buf_rd_addr = {~v_pos[1], h_visible[9:1]};

  always_ff @(posedge clk) begin
    color_q <= buf_rd_data;
  end

  // Sync and blank wait for buffer read plus color register
  always_comb begin
    sync_in.hsync = hsync;
    sync_in.blank = blank;
  end

  pipe_delay #(
    .T     (video_timing_pkg::sync_bundle_t),
    .DELAY (2)
  ) sync_delay (
    .clk   (clk),
    .reset (reset),
    .d     (sync_in),
    .q     (sync_q)
  );

  assign hsync_out = sync_q.hsync;
  assign vsync_out = vsync_late;
  assign de        = !sync_q.blank && !v_blank_late;

  // Top 6 bits of blue, green and red
  assign rgb = de ? {color_q[23:18], color_q[15:10], color_q[7:2]} : '0;

endmodule

// File: video_top.sv
// Single clock domain; host writes are one-cycle strobes with no acknowledge
`timescale 1ns/1ns

module video_top (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   host_wr,
  input  tile_pkg::host_target_t host_target,
  input  tile_pkg::host_addr_t   host_addr,
  input  tile_pkg::host_data_t   host_data,
  output logic                   hsync,
  output logic                   vsync,
  output logic                   de,
  output tile_pkg::rgb18_t       rgb
);

  // Timing to renderer
  video_timing_pkg::scan_pos_t h_pos;
  video_timing_pkg::scan_pos_t v_pos;
  video_timing_pkg::scan_pos_t h_visible;
  video_timing_pkg::scan_pos_t v_visible;
  logic                        timing_hsync;
  logic                        timing_blank;
  logic                        vsync_late;
  logic                        v_blank_late;

  tile_pkg::scroll_t scroll_x;
  tile_pkg::scroll_t scroll_y;

  // Fetch path
  tile_pkg::map_addr_t  map_addr;
  tile_pkg::tile_addr_t tile_addr;
  tile_pkg::pal_index_t pal_index;
  tile_pkg::tile_num_t  map_data;
  tile_pkg::tile_word_t tile_data;
  tile_pkg::color24_t   pal_data;

  // Line buffer ports
  logic                             buf_wr_en;
  video_timing_pkg::line_buf_addr_t buf_wr_addr;
  tile_pkg::color24_t               buf_wr_data;
  video_timing_pkg::line_buf_addr_t buf_rd_addr;
  tile_pkg::color24_t               buf_rd_data;

  display_timing timing (
    .clk          (clk),
    .reset        (reset),
    .h_pos        (h_pos),
    .v_pos        (v_pos),
    .hsync        (timing_hsync),
    .blank        (timing_blank),
    .h_visible    (h_visible),
    .v_visible    (v_visible),
    .vsync_late   (vsync_late),
    .v_blank_late (v_blank_late)
  );

  scroll_registers regs (
    .clk         (clk),
    .reset       (reset),
    .host_wr     (host_wr),
    .host_target (host_target),
    .host_addr   (host_addr),
    .host_data   (host_data),
    .scroll_x    (scroll_x),
    .scroll_y    (scroll_y)
  );

  tile_memories mems (
    .clk         (clk),
    .host_wr     (host_wr),
    .host_target (host_target),
    .host_addr   (host_addr),
    .host_data   (host_data),
    .map_addr    (map_addr),
    .tile_addr   (tile_addr),
    .pal_index   (pal_index),
    .map_data    (map_data),
    .tile_data   (tile_data),
    .pal_data    (pal_data)
  );

  line_buffer line_buf (
    .clk     (clk),
    .wr_en   (buf_wr_en),
    .wr_addr (buf_wr_addr),
    .wr_data (buf_wr_data),
    .rd_addr (buf_rd_addr),
    .rd_data (buf_rd_data)
  );

  tile_renderer renderer (
    .clk          (clk),
    .reset        (reset),
    .h_pos        (h_pos),
    .v_pos        (v_pos),
    .hsync        (timing_hsync),
    .blank        (timing_blank),
    .h_visible    (h_visible),
    .v_visible    (v_visible),
    .vsync_late   (vsync_late),
    .v_blank_late (v_blank_late),
    .scroll_x     (scroll_x),
    .scroll_y     (scroll_y),
    .map_addr     (map_addr),
    .tile_addr    (tile_addr),
    .pal_index    (pal_index),
    .map_data     (map_data),
    .tile_data    (tile_data),
    .pal_data     (pal_data),
    .buf_wr_en    (buf_wr_en),
    .buf_wr_addr  (buf_wr_addr),
    .buf_wr_data  (buf_wr_data),
    .buf_rd_addr  (buf_rd_addr),
    .buf_rd_data  (buf_rd_data),
    .hsync_out    (hsync),
    .vsync_out    (vsync),
    .de           (de),
    .rgb          (rgb)
  );

endmodule

// File: tb_video_top.sv
// Runs from the project root; pixels are only checked where every memory on their path was written
`timescale 1ns/1ns

`include "video_config.svh"

module tb_video_top;

  logic                   clk;
  logic                   reset;
  logic                   host_wr;
  tile_pkg::host_target_t host_target;
  tile_pkg::host_addr_t   host_addr;
  tile_pkg::host_data_t   host_data;
  logic                   hsync;
  logic                   vsync;
  logic                   de;
  tile_pkg::rgb18_t       rgb;

  // One entry per W or P line of the test file
  byte  cmd_kind [$];
  int   cmd_a [$];
  int   cmd_b [$];
  int   cmd_c [$];
  int   frames_used;
  logic tests_loaded;

  // Shadow copies of every host write
  tile_pkg::tile_num_t  shadow_map  [`MAP_DEPTH];
  tile_pkg::tile_word_t shadow_tile [`TILE_DEPTH];
  tile_pkg::color24_t   shadow_pal  [`PAL_DEPTH];
  tile_pkg::scroll_t    shadow_sx;
  tile_pkg::scroll_t    shadow_sy;

  // Visible pixels of the last captured frame
  tile_pkg::rgb18_t frame_rgb [`V_VISIBLE][`H_VISIBLE];

  video_top DUT (
    .clk         (clk),
    .reset       (reset),
    .host_wr     (host_wr),
    .host_target (host_target),
    .host_addr   (host_addr),
    .host_data   (host_data),
    .hsync       (hsync),
    .vsync       (vsync),
    .de          (de),
    .rgb         (rgb)
  );

  // 100 ns clock
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1, "stopping at the first failure");
  endtask

  task automatic check_rgb(input string name, input tile_pkg::rgb18_t got,
                           input tile_pkg::rgb18_t exp);
    if (got !== exp) begin
      report_failure($sformatf("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_sync(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      report_failure($sformatf("ERROR at %0t ns: %s is %b, expected %b", $time, name, got, exp));
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      report_failure($sformatf("ERROR at %0t ns: %s is %0d, expected %0d",
                               $time, name, got, exp));
    end
  endtask

  task automatic check_quiet;
    check_sync("hsync", hsync, 1'b0);
    check_sync("vsync", vsync, 1'b0);
    check_sync("de", de, 1'b0);
    check_rgb("rgb", rgb, '0);
  endtask

  task automatic load_tests;
    int    fd;
    int    n;
    int    a;
    int    b;
    int    c;
    byte   kind;
    byte   prev_kind;
    string line;
    fd = $fopen("video_tests.txt", "r");
    if (fd == 0) begin
      report_failure("could not open video_tests.txt for reading");
    end else begin
      prev_kind   = "W";
      frames_used = 0;
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        // Skip blank lines and the column header
        if ((n > 1) && (line.getc(0) != "#")) begin
          kind = line.getc(0);
          if (kind == "P") begin
            n = $sscanf(line.substr(1, line.len() - 1), "%d %d %h", a, b, c);
          end else begin
            n = $sscanf(line.substr(1, line.len() - 1), "%d %h %h", a, b, c);
          end
          if ((n != 3) || ((kind != "W") && (kind != "P"))) begin
            report_failure($sformatf("malformed line in video_tests.txt: %s", line));
          end
          // Each new run of P lines needs one fresh frame
          if ((kind == "P") && (prev_kind != "P")) begin
            frames_used++;
          end
          cmd_kind.push_back(kind);
          cmd_a.push_back(a);
          cmd_b.push_back(b);
          cmd_c.push_back(c);
          prev_kind = kind;
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic clear_shadows;
    int k;
    for (k = 0; k < `TILE_DEPTH; k++) begin
      shadow_tile[k[14:0]] = '0;
    end
    for (k = 0; k < `MAP_DEPTH; k++) begin
      shadow_map[k[9:0]] = '0;
    end
    for (k = 0; k < `PAL_DEPTH; k++) begin
      shadow_pal[k[7:0]] = '0;
    end
    shadow_sx = '0;
    shadow_sy = '0;
  endtask

  // Values change 10 ns after the edge and the DUT takes them on the next edge
  task automatic host_write(input int target, input int addr, input int data);
    @(posedge clk);
    #10;
    host_wr     = 1'b1;
    host_target = tile_pkg::host_target_t'(target[1:0]);
    host_addr   = addr[14:0];
    host_data   = data[23:0];
  endtask

  task automatic end_host_writes;
    @(posedge clk);
    #10;
    host_wr = 1'b0;
  endtask

  task automatic shadow_write(input int target, input int addr, input int data);
    case (target)
      0: begin
        if (addr[0]) begin
          shadow_sy = data[8:0];
        end else begin
          shadow_sx = data[8:0];
        end
      end
      1: shadow_map[addr[9:0]] = data[7:0];
      2: shadow_tile[addr[14:0]] = data[15:0];
      default: shadow_pal[addr[7:0]] = data[23:0];
    endcase
  endtask

  // Screen pixel to image pixel, then scroll in a 512 world, tile lookup and palette
  function automatic tile_pkg::rgb18_t expected_rgb(input int col, input int row);
    int                   wx;
    int                   wy;
    int                   map_index;
    int                   word_index;
    tile_pkg::tile_num_t  tile_num;
    tile_pkg::tile_word_t word;
    tile_pkg::pal_index_t index;
    tile_pkg::color24_t   color;
    wx = (col / 2 + int'(shadow_sx)) % 512;
    wy = (row / 2 + int'(shadow_sy)) % 512;
    map_index  = (wy / 16) * 32 + wx / 16;
    tile_num   = shadow_map[map_index[9:0]];
    word_index = int'(tile_num) * 128 + (wy % 16) * 8 + (wx % 16) / 2;
    word       = shadow_tile[word_index[14:0]];
    if ((wx % 2) == 1) begin
      index = word[15:8];
    end else begin
      index = word[7:0];
    end
    color = shadow_pal[index];
    return {color[23:18], color[15:10], color[7:2]};
  endfunction

  // Returns on the first low sample after a complete vsync pulse
  task automatic wait_frame_start;
    int high_clocks;
    high_clocks = 0;
    @(negedge clk);
    // A pulse already under way is not counted
    while (vsync === 1'b1) begin
      @(negedge clk);
    end
    while (vsync !== 1'b1) begin
      @(negedge clk);
    end
    while (vsync === 1'b1) begin
      check_sync("de", de, 1'b0);
      check_rgb("rgb", rgb, '0);
      high_clocks++;
      @(negedge clk);
    end
    check_count("vsync high clocks", high_clocks, 2 * `H_TOTAL);
  endtask

  // Rows and columns counted from de with sync timing checked along the way
  task automatic capture_frame;
    int   row;
    int   col;
    int   hs_width;
    int   since_rise;
    logic hs_seen;
    logic prev_de;
    logic prev_hs;
    row        = 0;
    col        = 0;
    hs_width   = 0;
    since_rise = 0;
    hs_seen    = 1'b0;
    prev_de    = 1'b0;
    prev_hs    = 1'b0;
    while (row < `V_VISIBLE) begin
      check_sync("vsync", vsync, 1'b0);
      if (de === 1'b1) begin
        if (col < `H_VISIBLE) begin
          frame_rgb[row[8:0]][col[9:0]] = rgb;
        end
        col++;
      end else begin
        check_rgb("rgb", rgb, '0);
        if (prev_de === 1'b1) begin
          check_count("de clocks per line", col, `H_VISIBLE);
          row++;
          col = 0;
        end
      end
      if (hsync === 1'b1) begin
        if (prev_hs !== 1'b1) begin
          if (hs_seen) begin
            check_count("hsync period", since_rise, `H_TOTAL);
          end
          hs_seen    = 1'b1;
          since_rise = 0;
          hs_width   = 0;
        end
        hs_width++;
      end else if ((prev_hs === 1'b1) && hs_seen) begin
        check_count("hsync width", hs_width, `H_SYNC_END - `H_SYNC_START);
      end
      since_rise++;
      prev_de = de;
      prev_hs = hsync;
      @(negedge clk);
    end
  endtask

  task automatic check_pixel(input int col, input int row, input int file_value);
    tile_pkg::rgb18_t exp;
    tile_pkg::rgb18_t from_rule;
    exp = file_value[17:0];
    if ((col < 0) || (col >= `H_VISIBLE) || (row < 0) || (row >= `V_VISIBLE)) begin
      report_failure($sformatf("pixel (%0d, %0d) in video_tests.txt is off screen", col, row));
    end else begin
      from_rule = expected_rgb(col, row);
      if (from_rule !== exp) begin
        report_failure($sformatf("video_tests.txt expects %h at (%0d, %0d), the writes give %h",
                                 exp, col, row, from_rule));
      end
      check_rgb($sformatf("rgb at (%0d, %0d)", col, row), frame_rgb[row[8:0]][col[9:0]], exp);
    end
  endtask

  // One frame per run of pixel checks plus one for startup
  initial begin
    int timeout_cycles;
    wait (tests_loaded === 1'b1);
    timeout_cycles = (frames_used + 1) * `H_TOTAL * `V_TOTAL;
    repeat (timeout_cycles) @(posedge clk);
    report_failure($sformatf("watchdog expired after %0d clocks before the tests finished",
                             timeout_cycles));
  end

  initial begin
    int   i;
    logic in_pixels;
    reset        = 1'b1;
    host_wr      = 1'b0;
    host_target  = tile_pkg::TGT_REG;
    host_addr    = '0;
    host_data    = '0;
    tests_loaded = 1'b0;
    clear_shadows();
    load_tests();
    tests_loaded = 1'b1;

    // Outputs quiet in reset and right after it
    repeat (5) @(posedge clk);
    #10;
    check_quiet();
    reset = 1'b0;
    @(negedge clk);
    check_quiet();

    in_pixels = 1'b0;
    for (i = 0; i < cmd_kind.size(); i++) begin
      if (cmd_kind[i] == "W") begin
        host_write(cmd_a[i], cmd_b[i], cmd_c[i]);
        shadow_write(cmd_a[i], cmd_b[i], cmd_c[i]);
        in_pixels = 1'b0;
      end else begin
        // A whole frame rendered after the writes
        if (!in_pixels) begin
          end_host_writes();
          wait_frame_start();
          capture_frame();
          in_pixels = 1'b1;
        end
        check_pixel(cmd_a[i], cmd_b[i], cmd_c[i]);
      end
    end
    end_host_writes();

    $display("TB PASSED");
    $finish;
  end

endmodule

// File: video_tests.txt
# W target(0 reg, 1 map, 2 tile, 3 palette) address(hex) data(hex)
# P column row (decimal) expected rgb18 (hex), checked on the frame after the W lines above it
W 3 002 FC8004
W 3 003 0C30F0
W 1 000 01
W 1 001 02
W 2 080 0302
W 2 11A 0203
P 0 0 3F801
P 1 1 3F801
P 2 0 333C
P 3 1 333C
P 40 6 333C
P 43 7 3F801
W 0 000 3FC
W 0 001 1FD
P 8 6 3F801
P 11 7 333C
P 48 12 333C
P 51 13 3F801
W 3 002 00FF00
P 8 6 00FC0
P 51 13 00FC0
P 11 7 333C

// File: list.f
+incdir+.
video_timing_pkg.sv
tile_pkg.sv
display_timing.sv
pipe_delay.sv
scroll_registers.sv
tile_memories.sv
line_buffer.sv
tile_renderer.sv
video_top.sv
tb_video_top.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing -j 0 --top-module tb_video_top -f list.f -o sim_tb_video_top &&
./obj_dir/sim_tb_video_top | tee /dev/stderr | grep -q "TB PASSED" &&
echo "simulation result: pass" ||
{ echo "simulation result: fail"; exit 1; }
